// File: dv/vc_link_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the two-lane virtual-channel link
// Random and directed traffic, per-VC scoreboard and concurrent checks
////////////////////////////////////////////////////////////////////////////

module vc_link_tb import vc_link_pkg::*; #(
  parameter vc_mode_e VcMode = vc_credit_based
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumCredits = 3;

  // Traffic phases
  localparam int ph_idle    = 0;
  localparam int ph_random  = 1;
  localparam int ph_latency = 2;
  localparam int ph_stall   = 3;
  localparam int ph_fair    = 4;

  // Phase lengths in cycles
  localparam int random_len = 400;
  localparam int lat_len    = 40;
  localparam int stall_len  = 20;
  localparam int resume_len = 12;
  localparam int fair_len   = 40;
  // Reset, drains between phases and slack
  localparam int total_len  = 6 + random_len + lat_len + stall_len + resume_len + fair_len + 200;

  logic                clk_i = 1'b0;
  logic                rst_n_i;
  vc_mask_t            up_valid_i;
  vc_mask_t            up_ready_o;
  flit_t [num_vcs-1:0] up_flit_i;
  vc_mask_t            dn_valid_o;
  vc_mask_t            dn_ready_i;
  flit_t [num_vcs-1:0] dn_flit_o;
  vc_mask_t            up_hs;
  vc_mask_t            dn_hs;

  integer seed         = 81;
  int     test_err [1:6] = '{default: 0};
  int     tests_ok     = 0;
  int     tests_bad    = 0;
  int     phase        = ph_idle;

  ////////////////////////////////////////////////////////////////////////////
  // State kept by the stimulus process, sampled by the checks
  ////////////////////////////////////////////////////////////////////////////

  // Phase whose stimulus is on the inputs, and its cycle index
  int          active_phase = ph_idle;
  int          phase_cyc    = 0;
  int          edge_cnt     = 0;
  // VC0 flits taken while its consumer is stalled
  int          stall_acc    = 0;
  int unsigned seq_cnt [num_vcs] = '{default: 0};
  flit_t       sb_q    [num_vcs][$];
  flit_t       sb_head [num_vcs] = '{default: '0};
  int          sb_cnt  [num_vcs] = '{default: 0};
  flit_t       last_in [num_vcs] = '{default: '0};
  logic        hs1_q    = 1'b0;
  vc_idx_t     last_win = '0;

  vc_link_top #(
    .VcMode    (VcMode),
    .NumCredits(NumCredits)
  ) dut (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .up_valid_i(up_valid_i),
    .up_ready_o(up_ready_o),
    .up_flit_i (up_flit_i),
    .dn_valid_o(dn_valid_o),
    .dn_ready_i(dn_ready_i),
    .dn_flit_o (dn_flit_o)
  );

  always #50 clk_i = ~clk_i;

  assign up_hs = up_valid_i & up_ready_o;
  assign dn_hs = dn_valid_o & dn_ready_i;

  // VC number on top, then sequence count, random low half
  function automatic flit_t make_flit(int unsigned vc, int unsigned seq);
    logic [31:0] rnd;
    rnd = $random(seed);
    return {vc[0], seq[14:0], rnd[15:0]};
  endfunction

  task automatic run_phase(input int p, input int cycles);
    phase <= p;
    repeat (cycles + 1) @(posedge clk_i);
  endtask

  // Idle until both buffers are empty and the credits are back
  task automatic drain();
    phase <= ph_idle;
    do begin
      @(posedge clk_i);
    end while (dn_valid_o != '0);
    repeat (4) @(posedge clk_i);
  endtask

  task automatic report_test(input int id, input string name);
    if (test_err[id] == 0) begin
      tests_ok++;
      $display("Test %0d %s: ok", id, name);
    end else begin
      tests_bad++;
      $display("Test %0d %s: FAILED with %0d errors", id, name, test_err[id]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard update and stimulus, one edge at a time
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : drive
    vc_mask_t    nxt_valid;
    vc_mask_t    nxt_ready;
    logic [31:0] rnd;
    edge_cnt = edge_cnt + 1;
    for (int v = 0; v < num_vcs; v++) begin
      if (dn_hs[v] && sb_q[v].size() != 0) begin
        void'(sb_q[v].pop_front());
      end
      if (up_hs[v]) begin
        sb_q[v].push_back(up_flit_i[v]);
        last_in[v]   = up_flit_i[v];
        seq_cnt[v]   = seq_cnt[v] + 1;
        up_flit_i[v] <= make_flit(v, seq_cnt[v]);
      end
      sb_cnt[v]  = sb_q[v].size();
      sb_head[v] = (sb_cnt[v] != 0) ? sb_q[v][0] : '0;
    end
    if (up_hs != '0) begin
      last_win = up_hs[1] ? vc_idx_t'(1) : vc_idx_t'(0);
    end
    hs1_q = up_hs[1];
    if (active_phase == ph_stall && !dn_ready_i[0] && up_hs[0]) begin
      stall_acc = stall_acc + 1;
    end
    // Switch phase, restart the cycle index
    if (phase != active_phase) begin
      active_phase = phase;
      phase_cyc    = 0;
      stall_acc    = 0;
    end else begin
      phase_cyc = phase_cyc + 1;
    end
    // Pending flits stay valid until taken
    nxt_valid = up_valid_i & ~up_hs;
    nxt_ready = '1;
    rnd       = $random(seed);
    case (active_phase)
      ph_random: begin
        nxt_valid = nxt_valid | rnd[1:0];
        // Consumer ready about three cycles in four
        nxt_ready = rnd[3:2] | rnd[5:4];
      end
      ph_latency: begin
        nxt_valid[0] = nxt_valid[0] | (phase_cyc % 4 == 0);
        nxt_valid[1] = 1'b0;
      end
      ph_stall: begin
        nxt_valid    = '1;
        nxt_ready[0] = (phase_cyc >= stall_len);
      end
      ph_fair: nxt_valid = '1;
      default: nxt_valid = '0;
    endcase
    up_valid_i <= nxt_valid;
    dn_ready_i <= nxt_ready;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Second reset edge up to the first cycle out of reset
  a_reset_state: assert property (@(posedge clk_i)
    (edge_cnt >= 1 && edge_cnt <= 4) |-> (up_ready_o == '0 && dn_valid_o == '0))
    else begin
      test_err[1]++;
      $display("Mismatch up_ready_o/dn_valid_o in reset: expected 0/0, actual %h/%h",
               $sampled(up_ready_o), $sampled(dn_valid_o));
    end

  for (genvar v = 0; v < num_vcs; v++) begin : gen_vc_checks
    a_no_extra: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dn_hs[v] |-> sb_cnt[v] != 0)
      else begin
        test_err[2]++;
        $display("VC%0d delivered a flit that was never accepted upstream", v);
      end

    a_in_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (dn_hs[v] && sb_cnt[v] != 0) |-> dn_flit_o[v] == sb_head[v])
      else begin
        test_err[2]++;
        $display("Mismatch dn_flit_o[%0d]: expected %h, actual %h",
                 v, $sampled(sb_head[v]), $sampled(dn_flit_o[v]));
      end

    // Empty buffer shows the accepted flit one cycle later
    a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (up_hs[v] && !dn_valid_o[v]) |=> (dn_valid_o[v] && dn_flit_o[v] == last_in[v]))
      else begin
        test_err[3]++;
        $display("Mismatch dn_valid_o[%0d]/dn_flit_o[%0d]: expected 1/%h, actual %h/%h",
                 v, v, $sampled(last_in[v]), $sampled(dn_valid_o[v]),
                 $sampled(dn_flit_o[v]));
      end

    a_alternate: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (active_phase == ph_fair && phase_cyc >= 1 && up_hs[v]) |-> last_win != vc_idx_t'(v))
      else begin
        test_err[6]++;
        $display("VC%0d won the link twice in a row while the other VC waited", v);
      end
  end

  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (active_phase == ph_stall && !dn_ready_i[0] && stall_acc >= NumCredits)
      |-> !up_ready_o[0])
    else begin
      test_err[4]++;
      $display("VC0 accepted more flits than its buffer holds while stalled");
    end

  a_credit_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (active_phase == ph_stall && $rose(dn_ready_i[0])) |-> stall_acc == NumCredits)
    else begin
      test_err[4]++;
      $display("Mismatch stall_acc: expected %h, actual %h", NumCredits, $sampled(stall_acc));
    end

  a_resume: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (active_phase == ph_stall && $rose(dn_ready_i[0])) |-> ##[0:6] up_hs[0])
    else begin
      test_err[4]++;
      $display("VC0 did not resume after its consumer became ready");
    end

  // Stalled VC0 must not hold the link away from VC1
  a_isolation: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (active_phase == ph_stall && !dn_ready_i[0] && phase_cyc >= 2) |-> (up_hs[1] || hs1_q))
    else begin
      test_err[5]++;
      $display("VC1 went two cycles without a transfer while VC0 was stalled");
    end

  a_link_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (active_phase == ph_fair) |-> up_hs != '0)
    else begin
      test_err[6]++;
      $display("Link idle while both VCs were waiting");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : run
    int total;
    rst_n_i    = 1'b0;
    up_valid_i = '0;
    dn_ready_i = '0;
    for (int v = 0; v < num_vcs; v++) begin
      up_flit_i[v] = make_flit(v, 0);
    end
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    report_test(1, "reset state");
    run_phase(ph_random, random_len);
    drain();
    report_test(2, "ordered lossless delivery");
    run_phase(ph_latency, lat_len);
    drain();
    report_test(3, "empty-buffer latency");
    run_phase(ph_stall, stall_len + resume_len);
    drain();
    report_test(4, "credit bound");
    report_test(5, "isolation");
    run_phase(ph_fair, fair_len);
    drain();
    report_test(6, "fairness");
    total = 0;
    for (int i = 1; i <= 6; i++) begin
      total += test_err[i];
    end
    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_ok, tests_bad, total);
    if (tests_bad == 0 && total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(total_len * 100);
    $display("Timeout: test sequence did not finish within %0d cycles", total_len);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: hw/vc_credit_counter.sv
////////////////////////////////////////////////////////////////////////////
// Credit counter for one VC
// Tracks free slots in the far-end buffer of a single virtual channel
////////////////////////////////////////////////////////////////////////////

module vc_credit_counter #(
  parameter int unsigned NumCredits = 3
) (
  input  logic clk_i,
  input  logic rst_n_i,
  // Credit pulse back from the receiver
  input  logic credit_give_i,
  // Link handshake on this VC
  input  logic credit_take_i,
  output logic credit_left_o
);

  localparam int unsigned cnt_width = $clog2(NumCredits + 1);

  logic [cnt_width-1:0] count_q, count_d;

  always_comb begin
    count_d = count_q;
    // Give and take together cancel out
    if (credit_take_i && !credit_give_i) begin
      count_d = count_q - 1'b1;
    end else if (credit_give_i && !credit_take_i) begin
      count_d = count_q + 1'b1;
    end
  end

  // Counter starts with the whole far-end buffer free
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= cnt_width'(NumCredits);
    end else begin
      count_q <= count_d;
    end
  end

  assign credit_left_o = (count_q != '0);

  // No transfer without a credit in hand
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_q == '0) |-> !(credit_take_i && !credit_give_i));

  // Receiver never returns more credits than it has slots
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_q == cnt_width'(NumCredits)) |-> !(credit_give_i && !credit_take_i));

endmodule

// File: hw/vc_link_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Virtual-channel link arbiter
// Forms VC requests by the selected rule and puts the winning flit on the
// shared physical link
////////////////////////////////////////////////////////////////////////////

module vc_link_arbiter import vc_link_pkg::*; #(
  parameter vc_mode_e    VcMode     = vc_naive,
  parameter int unsigned NumCredits = 3
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Upstream side, one lane per VC
  input  vc_mask_t            valid_i,
  output vc_mask_t            ready_o,
  input  flit_t [num_vcs-1:0] flit_i,
  // Physical link side
  input  vc_mask_t            link_ready_i,
  output link_t               link_o,
  input  vc_mask_t            credit_i
);

  vc_mask_t arb_req;
  logic     arb_req_out;
  logic     arb_gnt;
  flit_t    arb_flit;
  vc_idx_t  arb_idx;
  vc_mask_t link_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Request forming
  ////////////////////////////////////////////////////////////////////////////

  if (VcMode == vc_preempt_valid) begin : gen_preempt
    // Mask pulls a stuck VC off the link so the other one can pass
    vc_mask_t mask_q, mask_d;
    vc_idx_t  other_idx;

    assign other_idx = vc_idx_t'(num_vcs - 1) - arb_idx;

    always_comb begin
      mask_d = mask_q;
      if (arb_req_out) begin
        if (!arb_gnt) begin
          // Winner blocked, other VC could go
          if (valid_i[other_idx] && link_ready_i[other_idx]) begin
            mask_d = ~(vc_mask_t'(1) << arb_idx);
          end
        end else begin
          mask_d = '1;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        mask_q <= '1;
      end else begin
        mask_q <= mask_d;
      end
    end

    assign arb_req = valid_i & mask_q;

  end else if (VcMode == vc_credit_based) begin : gen_credit
    vc_mask_t credit_left;

    for (genvar v = 0; v < num_vcs; v++) begin : gen_vc
      vc_credit_counter #(
        .NumCredits   (NumCredits)
      ) i_credit_counter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .credit_give_i(credit_i[v]),
        .credit_take_i(link_o.valid[v] & link_ready_i[v]),
        .credit_left_o(credit_left[v])
      );

      // Credits in hand mean the far-end buffer has room for the flit
      a_credit_room: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        link_o.valid[v] |-> link_ready_i[v]);
    end

    assign arb_req = valid_i & credit_left;

  end else begin : gen_naive
    // Only VCs the receiver can take right now
    assign arb_req = valid_i & link_ready_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration and link drive
  ////////////////////////////////////////////////////////////////////////////

  // Single grant comes from the winner's lane
  assign arb_gnt = link_ready_i[arb_idx];

  vc_rr_arbiter i_rr_arbiter (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (arb_req),
    .flit_i (flit_i),
    .gnt_i  (arb_gnt),
    .gnt_o  (ready_o),
    .req_o  (arb_req_out),
    .flit_o (arb_flit),
    .idx_o  (arb_idx)
  );

  // One-hot valid of the winning VC
  always_comb begin
    link_valid          = '0;
    link_valid[arb_idx] = arb_req_out;
    link_o.valid        = link_valid;
    link_o.flit         = arb_flit;
  end

  // Mask handling only knows one other VC
  if (num_vcs != 2) begin : gen_num_vcs_check
    $fatal(1, "vc_link_arbiter supports two virtual channels only");
  end

  a_link_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(link_o.valid));

endmodule

// File: hw/vc_link_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Virtual-channel link definitions
// Flit and link types, VC count and arbitration modes shared by the
// transmit arbiter, the receive buffers and the link top level
////////////////////////////////////////////////////////////////////////////

package vc_link_pkg;

  // Two VCs share one physical link
  localparam int unsigned num_vcs = 2;

  // Payload width of one flit
  localparam int unsigned flit_width = 32;

  // One flit on the wire, payload only
  typedef logic [flit_width-1:0] flit_t;

  // One bit per VC
  typedef logic [num_vcs-1:0] vc_mask_t;

  // Index of a VC
  typedef logic [$clog2(num_vcs)-1:0] vc_idx_t;

  // Request rule of the link arbiter
  typedef enum logic [1:0] {
    // Valid and downstream ready
    vc_naive         = 2'd0,
    // Valid and preemption mask
    vc_preempt_valid = 2'd1,
    // Valid and credits left
    vc_credit_based  = 2'd2
  } vc_mode_e;

  // Physical link between the two routers
  typedef struct packed {
    // One-hot or zero, marks the VC of the flit
    vc_mask_t valid;
    flit_t    flit;
  } link_t;

endpackage

// File: hw/vc_link_receiver.sv
////////////////////////////////////////////////////////////////////////////
// Virtual-channel link receiver
// Per-VC flit FIFOs behind the physical link, one credit back per pop
////////////////////////////////////////////////////////////////////////////

module vc_link_receiver import vc_link_pkg::*; #(
  parameter int unsigned NumCredits = 3
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Physical link side
  input  link_t               link_i,
  output vc_mask_t            link_ready_o,
  // Consumer side, one lane per VC
  output vc_mask_t            dn_valid_o,
  input  vc_mask_t            dn_ready_i,
  output flit_t [num_vcs-1:0] dn_flit_o,
  // Credit pulses towards the arbiter
  output vc_mask_t            credit_o
);

  localparam int unsigned ptr_width = (NumCredits > 1) ? $clog2(NumCredits) : 1;
  localparam int unsigned cnt_width = $clog2(NumCredits + 1);

  typedef logic [ptr_width-1:0] ptr_t;
  typedef logic [cnt_width-1:0] cnt_t;

  // Consumer pops, registered into credit pulses
  vc_mask_t pop;
  vc_mask_t credit_q;

  // Wraps at the buffer depth, which need not be a power of two
  function automatic ptr_t ptr_next(ptr_t ptr);
    ptr_t nxt;
    if (ptr == ptr_t'(NumCredits - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Per-VC flit buffers
  ////////////////////////////////////////////////////////////////////////////

  for (genvar v = 0; v < num_vcs; v++) begin : gen_vc
    flit_t mem_q [NumCredits];
    ptr_t  wr_ptr_q;
    ptr_t  rd_ptr_q;
    cnt_t  count_q;
    logic  push;

    // Ready while a slot is free
    assign link_ready_o[v] = (count_q != cnt_t'(NumCredits));
    assign dn_valid_o[v]   = (count_q != '0);
    // Head of the buffer goes downstream
    assign dn_flit_o[v]    = mem_q[rd_ptr_q];

    assign push   = link_i.valid[v] & link_ready_o[v];
    assign pop[v] = dn_valid_o[v] & dn_ready_i[v];

    // Storage
    always_ff @(posedge clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q] <= link_i.flit;
      end
    end

    // Pointers and fill level
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= ptr_next(wr_ptr_q);
        end
        if (pop[v]) begin
          rd_ptr_q <= ptr_next(rd_ptr_q);
        end
        // Simultaneous push and pop keep the level
        if (push && !pop[v]) begin
          count_q <= count_q + 1'b1;
        end else if (pop[v] && !push) begin
          count_q <= count_q - 1'b1;
        end
      end
    end

    // Pointers meet only on an empty or a full buffer
    a_ptr_level: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wr_ptr_q == rd_ptr_q) == (count_q == '0 || count_q == cnt_t'(NumCredits)));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Credit return
  ////////////////////////////////////////////////////////////////////////////

  // Pulse lands in the cycle after the pop
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q <= '0;
    end else begin
      credit_q <= pop;
    end
  end

  assign credit_o = credit_q;

endmodule

// File: hw/vc_link_top.sv
////////////////////////////////////////////////////////////////////////////
// Two-lane virtual-channel link
// Transmit arbiter and receive buffers joined by one physical link
////////////////////////////////////////////////////////////////////////////

module vc_link_top import vc_link_pkg::*; #(
  parameter vc_mode_e    VcMode     = vc_credit_based,
  parameter int unsigned NumCredits = 3
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Upstream router output
  input  vc_mask_t            up_valid_i,
  output vc_mask_t            up_ready_o,
  input  flit_t [num_vcs-1:0] up_flit_i,
  // Downstream consumer
  output vc_mask_t            dn_valid_o,
  input  vc_mask_t            dn_ready_i,
  output flit_t [num_vcs-1:0] dn_flit_o
);

  // Shared wire and its per-VC back channels
  link_t    link;
  vc_mask_t link_ready;
  vc_mask_t credit_ret;

  vc_link_arbiter #(
    .VcMode      (VcMode),
    .NumCredits  (NumCredits)
  ) i_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (up_valid_i),
    .ready_o     (up_ready_o),
    .flit_i      (up_flit_i),
    .link_ready_i(link_ready),
    .link_o      (link),
    .credit_i    (credit_ret)
  );

  // Buffer depth matches the credits in flight
  vc_link_receiver #(
    .NumCredits  (NumCredits)
  ) i_receiver (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .link_i      (link),
    .link_ready_o(link_ready),
    .dn_valid_o  (dn_valid_o),
    .dn_ready_i  (dn_ready_i),
    .dn_flit_o   (dn_flit_o),
    .credit_o    (credit_ret)
  );

endmodule

// File: hw/vc_rr_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter over the VCs
// Picks one requesting VC, forwards its flit and index, moves on after grant
////////////////////////////////////////////////////////////////////////////

module vc_rr_arbiter import vc_link_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  vc_mask_t              req_i,
  input  flit_t [num_vcs-1:0]   flit_i,
  // Grant for the current winner only
  input  logic                  gnt_i,
  output vc_mask_t              gnt_o,
  output logic                  req_o,
  output flit_t                 flit_o,
  output vc_idx_t               idx_o
);

  // Highest priority VC for the current cycle
  vc_idx_t ptr_q, ptr_d;
  vc_idx_t win_idx;

  // Scan from the pointer, first requester wins
  always_comb begin : p_pick
    vc_idx_t cand;
    logic    found;
    found   = 1'b0;
    win_idx = ptr_q;
    for (int unsigned i = 0; i < num_vcs; i++) begin
      cand = vc_idx_t'((ptr_q + i) % num_vcs);
      if (!found && req_i[cand]) begin
        found   = 1'b1;
        win_idx = cand;
      end
    end
  end

  assign req_o  = |req_i;
  assign idx_o  = win_idx;
  assign flit_o = flit_i[win_idx];

  // Winner bit qualified by the downstream grant
  always_comb begin
    gnt_o          = '0;
    gnt_o[win_idx] = req_o & gnt_i;
  end

  // Pointer only moves past a winner that really transferred
  always_comb begin
    ptr_d = ptr_q;
    if (req_o && gnt_i) begin
      ptr_d = vc_idx_t'((win_idx + 1) % num_vcs);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_d;
    end
  end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o));

endmodule

// File: vc_link_top.f
hw/vc_link_pkg.sv
hw/vc_credit_counter.sv
hw/vc_rr_arbiter.sv
hw/vc_link_arbiter.sv
hw/vc_link_receiver.sv
hw/vc_link_top.sv
dv/vc_link_tb.sv
